/* ice_link.f */
+incdir+test
source/ice_line_pkg.sv
source/ice_data_pkg.sv
source/ice_fifo.sv
source/ice_ein_serializer.sv
source/ice_eout_sampler.sv
source/ice_link_top.sv
test/ice_link_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
log=sim.log
rm -rf obj_dir
verilator --binary --timing --top-module ice_link_tb -f ice_link.f -o ice_link_sim \
	> "$log" 2>&1 &&
	./obj_dir/ice_link_sim >> "$log" 2>&1 ||
	{ echo "Build or simulation did not complete, see $log"; exit 1; }
if grep -q "Errors found" "$log"; then
	echo "FAIL, see $log"
	exit 1
fi
echo "PASS"
exit 0

/* source/ice_data_pkg.sv */
`default_nettype none

// ***************************************************************************
// Payload types and queue sizes
// ***************************************************************************

package ice_data_pkg;

	localparam int ice_byte_bits = 8;

	typedef logic [ice_byte_bits-1:0] ice_byte_t;

	// Received byte with its first-of-frame flag
	typedef struct packed {
		logic first;
		ice_byte_t data;
	} rx_word_t;

	// Host writes are bursty, so the transmit side gets the deeper queue
	localparam int tx_fifo_depth = 16;
	localparam int rx_fifo_depth = 8;

endpackage

`default_nettype wire

/* source/ice_ein_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module ice_ein_serializer (
	input logic clk,
	input logic bit_ctr_reset,
	input ice_data_pkg::ice_byte_t fifo_din,
	input ice_line_pkg::clk_div_t clk_div,
	input logic goc_mode,
	input logic fragment,
	input logic fifo_empty,
	input logic start_tx,
	output logic fifo_re,
	output logic emo_out,
	output logic edi_out,
	output logic eci_out
);

ice_line_pkg::ein_state_t state;
ice_line_pkg::ein_state_t next_state;
ice_line_pkg::clk_div_t state_ctr;
ice_line_pkg::clk_div_t phase_last;
ice_line_pkg::clk_div_t bit_step_pt;
logic [2:0] bit_ctr;
logic phase_end;
logic next_emo_out;
logic next_edi_out;
logic next_eci_out;
logic bit_ctr_incr;
logic bit_ctr_clear;

assign phase_last = clk_div - ice_line_pkg::clk_div_t'(1);
assign bit_step_pt = clk_div - ice_line_pkg::clk_div_t'(3);  // Leaves room for the FIFO pop
assign phase_end = (state_ctr == phase_last);

// Pop the head byte as its last bit is done
assign fifo_re = bit_ctr_incr && (bit_ctr == 3'd7);

// ***************************************************************************
// State, phase counter, bit index and registered line outputs
// ***************************************************************************

always_ff @(posedge clk) begin
	if (bit_ctr_reset) begin
		state <= ice_line_pkg::reset;
		state_ctr <= '0;
		bit_ctr <= 3'd0;
		emo_out <= 1'b0;
		edi_out <= 1'b0;
		eci_out <= 1'b0;
	end else begin
		state <= next_state;
		emo_out <= next_emo_out;
		edi_out <= next_edi_out;
		eci_out <= next_eci_out;
		if (next_state != state)
			state_ctr <= '0;  // Every phase starts from zero
		else
			state_ctr <= state_ctr + 1'b1;
		if (bit_ctr_clear)
			bit_ctr <= 3'd0;
		else if (bit_ctr_incr)
			bit_ctr <= bit_ctr + 1'b1;
	end
end

// ***************************************************************************
// Frame sequencing
// ***************************************************************************

always_comb begin
	next_state = state;
	next_emo_out = 1'b1;  // EMO high throughout a frame
	next_edi_out = 1'b0;
	next_eci_out = 1'b0;
	bit_ctr_incr = 1'b0;
	bit_ctr_clear = 1'b0;
	case (state)
		ice_line_pkg::reset: begin
			next_emo_out = 1'b0;
			if (start_tx)
				next_state = ice_line_pkg::start_tx;
		end

		ice_line_pkg::start_tx: begin
			bit_ctr_clear = 1'b1;
			if (phase_end)
				next_state = ice_line_pkg::eci_neg1;
		end

		ice_line_pkg::eci_neg1: begin
			if (goc_mode)
				next_edi_out = 1'b1;
			else
				next_edi_out = edi_out;
			if (phase_end)
				next_state = ice_line_pkg::eci_neg2;
		end

		ice_line_pkg::eci_neg2: begin
			next_edi_out = fifo_din[bit_ctr];
			if (phase_end)
				next_state = ice_line_pkg::eci_pos1;
		end

		ice_line_pkg::eci_pos1: begin
			next_eci_out = 1'b1;
			next_edi_out = fifo_din[bit_ctr];
			if (phase_end) begin
				if (goc_mode)
					next_state = ice_line_pkg::eci_pos1_2;
				else
					next_state = ice_line_pkg::eci_pos2;
			end
		end

		// Extra low phase gives the second ECI edge of a GOC bit
		ice_line_pkg::eci_pos1_2: begin
			next_edi_out = fifo_din[bit_ctr];
			if (phase_end)
				next_state = ice_line_pkg::eci_pos2;
		end

		ice_line_pkg::eci_pos2: begin
			next_eci_out = 1'b1;
			next_edi_out = edi_out;  // Hold, the head byte may change here
			if (state_ctr == bit_step_pt) begin
				bit_ctr_incr = 1'b1;
			end else if (phase_end) begin
				if (fifo_empty && fragment)
					next_state = ice_line_pkg::fragment_wait;
				else if (fifo_empty)
					next_state = ice_line_pkg::reset;
				else
					next_state = ice_line_pkg::eci_neg1;
			end
		end

		ice_line_pkg::fragment_wait: begin
			if (start_tx)
				next_state = ice_line_pkg::start_tx;
		end
	endcase
end

endmodule

`default_nettype wire

/* source/ice_eout_sampler.sv */
`timescale 1ns/1ps
`default_nettype none

module ice_eout_sampler (
	input logic clk,
	input logic bit_ctr_reset,
	input logic emo_in,
	input logic edi_in,
	input logic eci_in,
	input logic goc_mode,
	output ice_data_pkg::rx_word_t rx_word,
	output logic rx_push,
	input logic fifo_full,
	output logic rx_overflow
);

logic [1:0] emo_sync;
logic [1:0] edi_sync;
logic [2:0] eci_sync;  // Third stage only for edge detection
logic eci_rise;
logic take_bit;
logic skip_edge;
logic first_flag;
logic [2:0] bit_cnt;
logic push_pending;
logic word_first;
ice_data_pkg::ice_byte_t data_sr;

// ***************************************************************************
// Line synchronizers and ECI edge detection
// ***************************************************************************

always_ff @(posedge clk) begin
	if (bit_ctr_reset) begin
		emo_sync <= 2'b00;
		edi_sync <= 2'b00;
		eci_sync <= 3'b000;
	end else begin
		emo_sync <= {emo_sync[0], emo_in};
		edi_sync <= {edi_sync[0], edi_in};
		eci_sync <= {eci_sync[1:0], eci_in};
	end
end

assign eci_rise = eci_sync[1] && !eci_sync[2];

// Second edge of a GOC pair carries no new bit
assign take_bit = emo_sync[1] && eci_rise && !skip_edge;

// ***************************************************************************
// Bit counting and byte push
// ***************************************************************************

always_ff @(posedge clk) begin
	if (bit_ctr_reset) begin
		bit_cnt <= 3'd0;
		skip_edge <= 1'b0;
		first_flag <= 1'b1;
		push_pending <= 1'b0;
		rx_overflow <= 1'b0;
	end else begin
		push_pending <= 1'b0;
		if (!emo_sync[1]) begin  // Rearm between frames
			bit_cnt <= 3'd0;
			skip_edge <= 1'b0;
			first_flag <= 1'b1;
		end else if (eci_rise) begin
			skip_edge <= goc_mode && !skip_edge;
			if (take_bit) begin
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == 3'd7) begin
					push_pending <= 1'b1;
					first_flag <= 1'b0;
				end
			end
		end
		if (push_pending && fifo_full)
			rx_overflow <= 1'b1;  // Sticky until reset
	end
end

// LSB arrives first
always_ff @(posedge clk) begin
	if (take_bit) begin
		data_sr <= {edi_sync[1], data_sr[7:1]};
		if (bit_cnt == 3'd7)
			word_first <= first_flag;
	end
end

assign rx_word.first = word_first;
assign rx_word.data = data_sr;
assign rx_push = push_pending && !fifo_full;

endmodule

`default_nettype wire

/* source/ice_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module ice_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int depth = 16
) (
	input logic clk,
	input logic bit_ctr_reset,
	input payload_t wr_data,
	input logic wr_en,
	input logic rd_en,
	output payload_t rd_data,
	output logic empty,
	output logic full
);

localparam int ptr_w = $clog2(depth);
localparam int cnt_w = $clog2(depth + 1);

payload_t mem [depth];
logic [ptr_w-1:0] wr_ptr;
logic [ptr_w-1:0] rd_ptr;
logic [cnt_w-1:0] count;
logic do_write;
logic do_read;

// Wrap at depth, which need not be a power of two
function automatic logic [ptr_w-1:0] ptr_step(input logic [ptr_w-1:0] ptr);
	if (ptr == ptr_w'(depth - 1))
		return '0;
	return ptr + 1'b1;
endfunction

assign do_write = wr_en && !full;  // Dropped when full
assign do_read = rd_en && !empty;

assign empty = (count == '0);
assign full = (count == cnt_w'(depth));

// Show-ahead head entry
assign rd_data = mem[rd_ptr];

always_ff @(posedge clk) begin
	if (do_write)
		mem[wr_ptr] <= wr_data;
end

always_ff @(posedge clk) begin
	if (bit_ctr_reset) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count <= '0;
	end else begin
		if (do_write)
			wr_ptr <= ptr_step(wr_ptr);
		if (do_read)
			rd_ptr <= ptr_step(rd_ptr);
		case ({do_write, do_read})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: count <= count;  // Idle or both at once
		endcase
	end
end

endmodule

`default_nettype wire

/* source/ice_line_pkg.sv */
`default_nettype none

// ***************************************************************************
// Line timing for the EMO/EDI/ECI link
// ***************************************************************************

package ice_line_pkg;

	// Width of the divider value and of the phase counter
	localparam int clk_div_log2 = 22;

	typedef logic [clk_div_log2-1:0] clk_div_t;

	// Serializer frame states, one phase per state while a bit is on the line
	typedef enum logic [2:0] {
		reset         = 3'd0,
		start_tx      = 3'd1,
		eci_neg1      = 3'd2,  // ECI low, EDI high in GOC mode
		eci_neg2      = 3'd3,  // Data bit onto EDI
		eci_pos1      = 3'd4,
		eci_pos1_2    = 3'd5,  // GOC only
		eci_pos2      = 3'd6,
		fragment_wait = 3'd7   // EMO held high, waiting for start_tx
	} ein_state_t;

endpackage

`default_nettype wire

/* source/ice_link_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ice_link_top (
	input logic clk,
	input logic bit_ctr_reset,

	// Host transmit side
	input ice_data_pkg::ice_byte_t tx_data,
	input logic tx_write,
	output logic tx_full,
	input ice_line_pkg::clk_div_t clk_div,
	input logic goc_mode,
	input logic fragment,
	input logic start_tx,

	// Host receive side
	input logic rx_read,
	output ice_data_pkg::ice_byte_t rx_data,
	output logic rx_first,
	output logic rx_valid,
	output logic rx_overflow,

	// Line outputs
	output logic emo_out,
	output logic edi_out,
	output logic eci_out,

	// Line inputs
	input logic emo_in,
	input logic edi_in,
	input logic eci_in
);

ice_data_pkg::ice_byte_t tx_head;
logic tx_empty;
logic tx_re;
ice_data_pkg::rx_word_t rx_word;
logic rx_push;
logic rx_full;
ice_data_pkg::rx_word_t rx_head;
logic rx_empty;

// ***************************************************************************
// Transmit path
// ***************************************************************************

ice_fifo #(
	.payload_t(ice_data_pkg::ice_byte_t),
	.depth(ice_data_pkg::tx_fifo_depth)
) tx_fifo_i (
	.clk(clk),
	.bit_ctr_reset(bit_ctr_reset),
	.wr_data(tx_data),
	.wr_en(tx_write),
	.rd_en(tx_re),
	.rd_data(tx_head),
	.empty(tx_empty),
	.full(tx_full)
);

ice_ein_serializer ice_ein_serializer_i (
	.clk(clk),
	.bit_ctr_reset(bit_ctr_reset),
	.fifo_din(tx_head),
	.clk_div(clk_div),
	.goc_mode(goc_mode),
	.fragment(fragment),
	.fifo_empty(tx_empty),
	.start_tx(start_tx),
	.fifo_re(tx_re),
	.emo_out(emo_out),
	.edi_out(edi_out),
	.eci_out(eci_out)
);

// ***************************************************************************
// Receive path
// ***************************************************************************

ice_eout_sampler ice_eout_sampler_i (
	.clk(clk),
	.bit_ctr_reset(bit_ctr_reset),
	.emo_in(emo_in),
	.edi_in(edi_in),
	.eci_in(eci_in),
	.goc_mode(goc_mode),
	.rx_word(rx_word),
	.rx_push(rx_push),
	.fifo_full(rx_full),
	.rx_overflow(rx_overflow)
);

ice_fifo #(
	.payload_t(ice_data_pkg::rx_word_t),
	.depth(ice_data_pkg::rx_fifo_depth)
) rx_fifo_i (
	.clk(clk),
	.bit_ctr_reset(bit_ctr_reset),
	.wr_data(rx_word),
	.wr_en(rx_push),
	.rd_en(rx_read),
	.rd_data(rx_head),
	.empty(rx_empty),
	.full(rx_full)
);

assign rx_valid = !rx_empty;
assign rx_first = rx_head.first;  // Head entry split for the host
assign rx_data = rx_head.data;

endmodule

`default_nettype wire

/* test/ice_link_tests.svh */
`ifndef ice_link_tests_svh
`define ice_link_tests_svh

// ***************************************************************************
// Drive helpers, each returns on a falling edge
// ***************************************************************************

task automatic setup_link(input int div, input logic goc, input logic frag);
	clk_div = ice_line_pkg::clk_div_t'(div);
	goc_mode = goc;
	fragment = frag;
	@(negedge clk);
endtask

task automatic write_tx(input ice_data_pkg::ice_byte_t b);
	tx_data = b;
	tx_write = 1'b1;
	@(negedge clk);
	tx_write = 1'b0;
endtask

task automatic pulse_start();
	start_tx = 1'b1;
	@(negedge clk);
	start_tx = 1'b0;
endtask

// Cycles allowed for one byte on the line
function automatic int byte_limit(input int div);
	return 2 * 5 * 9 * div;
endfunction

task automatic wait_emo(input logic level, input int limit);
	int waited;
	waited = 0;
	while (emo_out !== level && waited < limit) begin
		@(negedge clk);
		waited++;
	end
	if (emo_out !== level) begin
		errors++;
		$display("timeout: emo_out did not go to %b within %0d cycles", level, limit);
	end
endtask

task automatic pop_rx(input ice_data_pkg::ice_byte_t exp_data, input logic exp_first,
		input int limit);
	int waited;
	waited = 0;
	while (rx_valid !== 1'b1 && waited < limit) begin
		@(negedge clk);
		waited++;
	end
	if (rx_valid !== 1'b1) begin
		errors++;
		$display("timeout: no received byte within %0d cycles", limit);
	end else begin
		check_byte("rx_data", rx_data, exp_data);
		check_flag("rx_first", rx_first, exp_first);
		rx_read = 1'b1;
		@(negedge clk);
		rx_read = 1'b0;
	end
endtask

// Normal bits give one ECI rise per 4 phases, GOC bits two rises 2 then 3 phases apart
task automatic check_edge_spacing(input int div, input int num_edges, input logic goc);
	int gap;
	int i;
	check_count("eci_out edges", ice_line_pkg::clk_div_t'(eci_edges.size()),
		ice_line_pkg::clk_div_t'(num_edges));
	for (i = 1; i < eci_edges.size(); i++) begin
		if (!goc)
			gap = 4 * div;
		else if (i % 2 == 1)
			gap = 2 * div;
		else
			gap = 3 * div;
		check_count("eci_out edge spacing",
			ice_line_pkg::clk_div_t'(eci_edges[i] - eci_edges[i - 1]),
			ice_line_pkg::clk_div_t'(gap));
	end
endtask

// ***************************************************************************
// Directed tests
// ***************************************************************************

task automatic test_reset_state();
	int err0;
	err0 = errors;
	check_flag("emo_out", emo_out, 1'b0);
	check_flag("edi_out", edi_out, 1'b0);
	check_flag("eci_out", eci_out, 1'b0);
	check_flag("rx_valid", rx_valid, 1'b0);
	check_flag("rx_overflow", rx_overflow, 1'b0);
	check_flag("tx_full", tx_full, 1'b0);
	report_test("reset_state", err0);
endtask

task automatic test_single_byte();
	int err0;
	ice_data_pkg::ice_byte_t b;
	err0 = errors;
	b = 8'h4b;  // Not a bit palindrome, so LSB order shows
	setup_link(single_div, 1'b0, 1'b0);
	eci_edges.delete();
	write_tx(b);
	pulse_start();
	pop_rx(b, 1'b1, byte_limit(single_div));
	wait_emo(1'b0, byte_limit(single_div));
	check_flag("emo_out", emo_out, 1'b0);
	check_edge_spacing(single_div, 8, 1'b0);
	report_test("single_byte", err0);
endtask

task automatic test_goc_mode();
	int err0;
	int i;
	ice_data_pkg::ice_byte_t sent [goc_bytes];
	err0 = errors;
	setup_link(goc_div, 1'b1, 1'b0);
	eci_edges.delete();
	for (i = 0; i < goc_bytes; i++) begin
		random_byte(sent[i]);
		write_tx(sent[i]);
	end
	pulse_start();
	for (i = 0; i < goc_bytes; i++)
		pop_rx(sent[i], i == 0, byte_limit(goc_div));
	wait_emo(1'b0, byte_limit(goc_div));
	check_edge_spacing(goc_div, 16 * goc_bytes, 1'b1);
	report_test("goc_mode", err0);
endtask

task automatic test_fragment();
	int err0;
	int i;
	ice_data_pkg::ice_byte_t sent [frag_bytes];
	err0 = errors;
	setup_link(frag_div, 1'b0, 1'b1);
	for (i = 0; i < frag_bytes; i++)
		random_byte(sent[i]);
	write_tx(sent[0]);
	write_tx(sent[1]);
	pulse_start();
	pop_rx(sent[0], 1'b1, byte_limit(frag_div));
	pop_rx(sent[1], 1'b0, byte_limit(frag_div));
	repeat (4 * frag_div) @(negedge clk);  // Last ECI high phase is over by now
	check_flag("emo_out", emo_out, 1'b1);
	check_flag("rx_valid", rx_valid, 1'b0);
	write_tx(sent[2]);
	write_tx(sent[3]);
	fragment = 1'b0;
	pulse_start();
	pop_rx(sent[2], 1'b0, byte_limit(frag_div));
	pop_rx(sent[3], 1'b0, byte_limit(frag_div));
	wait_emo(1'b0, byte_limit(frag_div));
	check_flag("emo_out", emo_out, 1'b0);
	report_test("fragment", err0);
endtask

task automatic test_overflow();
	int err0;
	int i;
	ice_data_pkg::ice_byte_t sent [ovf_bytes];
	err0 = errors;
	setup_link(ovf_div, 1'b0, 1'b0);
	for (i = 0; i < ovf_bytes; i++) begin
		random_byte(sent[i]);
		write_tx(sent[i]);
	end
	pulse_start();
	wait_emo(1'b1, 4);
	wait_emo(1'b0, ovf_bytes * byte_limit(ovf_div));
	check_flag("rx_overflow", rx_overflow, 1'b1);
	for (i = 0; i < ice_data_pkg::rx_fifo_depth; i++)
		pop_rx(sent[i], i == 0, 4);
	check_flag("rx_valid", rx_valid, 1'b0);
	report_test("overflow", err0);
endtask

task automatic test_back_to_back();
	int err0;
	int i;
	ice_data_pkg::ice_byte_t sent [b2b_bytes];
	err0 = errors;
	setup_link(b2b_div, 1'b0, 1'b0);
	for (i = 0; i < b2b_bytes; i++)
		random_byte(sent[i]);
	write_tx(sent[0]);
	write_tx(sent[1]);
	pulse_start();
	wait_emo(1'b1, 4);
	wait_emo(1'b0, 2 * byte_limit(b2b_div));
	write_tx(sent[2]);
	write_tx(sent[3]);
	pulse_start();
	wait_emo(1'b1, 4);
	wait_emo(1'b0, 2 * byte_limit(b2b_div));
	for (i = 0; i < b2b_bytes; i++)
		pop_rx(sent[i], i % 2 == 0, 4);  // Two bytes per frame
	report_test("back_to_back", err0);
endtask

`endif

/* test/ice_link_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ice_link_tb;

localparam int clk_period = 8;
localparam int reset_cycles = 8;
localparam int single_div = 4;
localparam int goc_div = 6;
localparam int goc_bytes = 6;
localparam int frag_div = 5;
localparam int frag_bytes = 4;
localparam int ovf_div = 4;
localparam int ovf_bytes = 10;
localparam int b2b_div = 4;
localparam int b2b_bytes = 4;

// Budget of 5*clk_div*9 cycles per byte over all tests, doubled
localparam int watchdog_cycles = reset_cycles + 2 * 5 * 9 * (single_div
	+ goc_div * goc_bytes + frag_div * frag_bytes + ovf_div * ovf_bytes
	+ b2b_div * b2b_bytes);

logic clk = 1'b0;
logic bit_ctr_reset;
ice_data_pkg::ice_byte_t tx_data;
logic tx_write;
logic tx_full;
ice_line_pkg::clk_div_t clk_div;
logic goc_mode;
logic fragment;
logic start_tx;
logic rx_read;
ice_data_pkg::ice_byte_t rx_data;
logic rx_first;
logic rx_valid;
logic rx_overflow;
logic emo_out;
logic edi_out;
logic eci_out;

int errors = 0;
int checks = 0;
int tests = 0;
int cycle = 0;
int eci_edges[$];  // Cycle numbers of eci_out rising edges
logic eci_prev = 1'b0;
logic [31:0] lfsr_state = 32'h9e534ce4;

always #(clk_period / 2) clk = ~clk;

always @(posedge clk)
	cycle <= cycle + 1;

always @(negedge clk) begin
	if (eci_out === 1'b1 && eci_prev === 1'b0)
		eci_edges.push_back(cycle);
	eci_prev = eci_out;
end

// Line outputs looped straight back to the sampler
ice_link_top ice_link_top_i (
	.clk(clk),
	.bit_ctr_reset(bit_ctr_reset),
	.tx_data(tx_data),
	.tx_write(tx_write),
	.tx_full(tx_full),
	.clk_div(clk_div),
	.goc_mode(goc_mode),
	.fragment(fragment),
	.start_tx(start_tx),
	.rx_read(rx_read),
	.rx_data(rx_data),
	.rx_first(rx_first),
	.rx_valid(rx_valid),
	.rx_overflow(rx_overflow),
	.emo_out(emo_out),
	.edi_out(edi_out),
	.eci_out(eci_out),
	.emo_in(emo_out),
	.edi_in(edi_out),
	.eci_in(eci_out)
);

// ***************************************************************************
// Random bytes and result checks
// ***************************************************************************

// Galois form, taps x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	if (s[0])
		return (s >> 1) ^ 32'h80200003;
	return s >> 1;
endfunction

task automatic random_byte(output ice_data_pkg::ice_byte_t b);
	int i;
	for (i = 0; i < 8; i++) begin
		b[i] = lfsr_state[0];
		lfsr_state = lfsr_next(lfsr_state);
	end
endtask

task automatic check_byte(input string name, input ice_data_pkg::ice_byte_t got,
		input ice_data_pkg::ice_byte_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
	end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("error at %0d ns: %s is %b, expected %b", $time, name, got, exp);
	end
endtask

task automatic check_count(input string name, input ice_line_pkg::clk_div_t got,
		input ice_line_pkg::clk_div_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("error at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
	end
endtask

task automatic report_test(input string name, input int errors_before);
	tests++;
	$display("test %-12s done, %0d errors", name, errors - errors_before);
endtask

`include "ice_link_tests.svh"

initial begin
	#(watchdog_cycles * clk_period);
	$display("watchdog expired, the tests did not finish within %0d cycles",
		watchdog_cycles);
	$display("Errors found");
	$finish;
end

initial begin
	bit_ctr_reset = 1'b1;
	tx_data = '0;
	tx_write = 1'b0;
	clk_div = ice_line_pkg::clk_div_t'(single_div);
	goc_mode = 1'b0;
	fragment = 1'b0;
	start_tx = 1'b0;
	rx_read = 1'b0;
	repeat (reset_cycles) @(negedge clk);
	bit_ctr_reset = 1'b0;
	@(negedge clk);
	test_reset_state();
	test_single_byte();
	test_goc_mode();
	test_fragment();
	test_overflow();
	test_back_to_back();
	$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
	if (errors == 0)
		$display("No errors");
	else
		$display("Errors found");
	$finish;
end

endmodule

`default_nettype wire
